// File: fetch_config.svh
// Fetch stage global constants

`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// Address and instruction word width
`define FETCH_ADDR_W 32

// Entries in the fetch buffer
`define FETCH_DEPTH 3

// Width of buffer occupancy and outstanding counters
`define FETCH_CNT_W 2

// Bus transactions allowed in flight at once
`define FETCH_MAX_OUTSTANDING 2

// Upper mtvec bits that sit above seven zero bits
`define MTVEC_BASE_W 25

// Vectored interrupt index width
`define IRQ_INDEX_W 5

`endif

// File: fetch_pkg.sv
// Fetch stage types

`include "fetch_config.svh"

package fetch_pkg;

  ////////////////////
  // Enums
  ////////////////////

  // Sources of the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT,
    PC_JUMP,
    PC_BRANCH,
    PC_MRET,
    PC_TRAP_EXC,
    PC_TRAP_IRQ,
    PC_DBG_HALT
  } pc_mux_e;

  ////////////////////
  // Structs
  ////////////////////

  // Control strobes and levels from the core controller
  typedef struct packed {
    logic                    pc_set;
    pc_mux_e                 pc_mux;
    logic                    kill_if;
    logic                    halt_if;
    logic [`IRQ_INDEX_W-1:0] irq_index;
  } fetch_ctrl_t;

  // Redirect targets
  typedef struct packed {
    logic [`FETCH_ADDR_W-1:0] boot_addr;
    logic [`FETCH_ADDR_W-1:0] jump_target;
    logic [`FETCH_ADDR_W-1:0] branch_target;
    logic [`FETCH_ADDR_W-1:0] mepc;
    logic [`FETCH_ADDR_W-1:0] dm_halt_addr;
    logic [`MTVEC_BASE_W-1:0] mtvec_base;
  } fetch_targets_t;

  // Bus request from the prefetcher
  typedef struct packed {
    logic [`FETCH_ADDR_W-1:0] addr;
  } fetch_req_t;

  // Bus response
  typedef struct packed {
    logic [`FETCH_ADDR_W-1:0] rdata;
    logic                     err;
  } instr_resp_t;

  // One fetch buffer entry
  typedef struct packed {
    instr_resp_t              resp;
    logic [`FETCH_ADDR_W-1:0] addr;
  } fetch_entry_t;

  // IF/ID pipeline register contents
  typedef struct packed {
    logic                     instr_valid;
    logic [`FETCH_ADDR_W-1:0] instr;
    logic [`FETCH_ADDR_W-1:0] pc;
    logic                     bus_err;
  } if_id_pipe_t;

endpackage

// File: pc_select.sv
// Next fetch address mux

`timescale 1ns/100ps

`include "fetch_config.svh"

module pc_select (
  input  fetch_pkg::fetch_ctrl_t    ctrl_i,
  input  fetch_pkg::fetch_targets_t targets_i,
  output logic [`FETCH_ADDR_W-1:0]  branch_addr_o
);

  import fetch_pkg::*;

  ////////////////////
  // Address select
  ////////////////////

  always_comb begin
    // Boot address as fallback
    branch_addr_o = {targets_i.boot_addr[`FETCH_ADDR_W-1:2], 2'b00};

    case (ctrl_i.pc_mux)
      // Boot forced to word alignment
      PC_BOOT:     branch_addr_o = {targets_i.boot_addr[`FETCH_ADDR_W-1:2], 2'b00};
      PC_JUMP:     branch_addr_o = targets_i.jump_target;
      PC_BRANCH:   branch_addr_o = targets_i.branch_target;
      // Return from exception or interrupt
      PC_MRET:     branch_addr_o = targets_i.mepc;
      // All exceptions land on the mtvec base
      PC_TRAP_EXC: begin
        branch_addr_o = {targets_i.mtvec_base, {(`FETCH_ADDR_W-`MTVEC_BASE_W){1'b0}}};
      end
      // Vectored interrupts at base plus index times four
      PC_TRAP_IRQ: begin
        branch_addr_o = {targets_i.mtvec_base, ctrl_i.irq_index, 2'b00};
      end
      // Debug halt entry forced to word alignment
      PC_DBG_HALT: begin
        branch_addr_o = {targets_i.dm_halt_addr[`FETCH_ADDR_W-1:2], 2'b00};
      end
      default: begin
        branch_addr_o = {targets_i.boot_addr[`FETCH_ADDR_W-1:2], 2'b00};
      end
    endcase
  end

endmodule

// File: prefetch_ctrl.sv
// Prefetch controller

`timescale 1ns/100ps

`include "fetch_config.svh"

module prefetch_ctrl (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          pc_set_i,
  input  logic [`FETCH_ADDR_W-1:0]      branch_addr_i,
  input  logic                          trans_ready_i,
  input  logic                          resp_valid_i,
  input  fetch_pkg::instr_resp_t        resp_i,
  input  logic [`FETCH_CNT_W-1:0]       fifo_count_i,
  output logic                          trans_valid_o,
  output fetch_pkg::fetch_req_t         trans_o,
  output logic                          push_o,
  output fetch_pkg::fetch_entry_t       push_entry_o,
  output logic                          busy_o,
  output logic                          protocol_err_o
);

  logic                     fetch_en_q;
  logic [`FETCH_ADDR_W-1:0] fetch_addr_q;
  logic [`FETCH_ADDR_W-1:0] resp_addr_q;
  logic [`FETCH_CNT_W-1:0]  outstnd_cnt_q;
  logic [`FETCH_CNT_W-1:0]  outstnd_cnt_d;
  logic [`FETCH_CNT_W-1:0]  discard_cnt_q;
  logic [`FETCH_CNT_W:0]    space_used;
  logic                     handover;
  logic                     resp_taken;
  logic                     protocol_err_q;

  ////////////////////
  // Issue side
  ////////////////////

  // Buffered words plus words still on the bus
  assign space_used = {1'b0, fifo_count_i} + {1'b0, outstnd_cnt_q};

  // No handover in the redirect cycle itself
  assign trans_valid_o = fetch_en_q && !pc_set_i &&
                         (outstnd_cnt_q < `FETCH_CNT_W'(`FETCH_MAX_OUTSTANDING)) &&
                         (space_used < (`FETCH_CNT_W+1)'(`FETCH_DEPTH));
  assign trans_o.addr  = fetch_addr_q;
  assign handover      = trans_valid_o && trans_ready_i;

  ////////////////////
  // Response side
  ////////////////////

  // A response only counts when something is outstanding
  assign resp_taken = resp_valid_i && (outstnd_cnt_q != '0);

  // Stale responses after a redirect are dropped here
  assign push_o            = resp_taken && (discard_cnt_q == '0) && !pc_set_i;
  assign push_entry_o.resp = resp_i;
  assign push_entry_o.addr = resp_addr_q;

  always_comb begin
    outstnd_cnt_d = outstnd_cnt_q;
    if (handover) begin
      outstnd_cnt_d = outstnd_cnt_d + 1'b1;
    end
    if (resp_taken) begin
      outstnd_cnt_d = outstnd_cnt_d - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_en_q     <= 1'b0;
      outstnd_cnt_q  <= '0;
      discard_cnt_q  <= '0;
      protocol_err_q <= 1'b0;
    end else begin
      outstnd_cnt_q  <= outstnd_cnt_d;
      protocol_err_q <= resp_valid_i && (outstnd_cnt_q == '0);
      // First redirect after reset starts fetching
      if (pc_set_i) begin
        fetch_en_q <= 1'b1;
      end
      // Everything still in flight becomes a discard
      if (pc_set_i) begin
        discard_cnt_q <= outstnd_cnt_d;
      end else if (resp_taken && (discard_cnt_q != '0)) begin
        discard_cnt_q <= discard_cnt_q - 1'b1;
      end
    end
  end

  // Next fetch address and address of oldest live response
  always_ff @(posedge clk) begin
    if (pc_set_i) begin
      fetch_addr_q <= branch_addr_i;
      resp_addr_q  <= branch_addr_i;
    end else begin
      if (handover) begin
        fetch_addr_q <= fetch_addr_q + `FETCH_ADDR_W'(4);
      end
      if (push_o) begin
        resp_addr_q <= resp_addr_q + `FETCH_ADDR_W'(4);
      end
    end
  end

  assign busy_o         = (outstnd_cnt_q != '0);
  assign protocol_err_o = protocol_err_q;

endmodule

// File: fetch_fifo.sv
// Fetch buffer

`timescale 1ns/100ps

`include "fetch_config.svh"

module fetch_fifo (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    flush_i,
  input  logic                    push_i,
  input  fetch_pkg::fetch_entry_t push_entry_i,
  input  logic                    pop_i,
  output logic                    valid_o,
  output fetch_pkg::fetch_entry_t entry_o,
  output logic [`FETCH_CNT_W-1:0] count_o
);

  import fetch_pkg::*;

  fetch_entry_t            mem_q [`FETCH_DEPTH];
  logic [`FETCH_CNT_W-1:0] rd_ptr_q;
  logic [`FETCH_CNT_W-1:0] wr_ptr_q;
  logic [`FETCH_CNT_W-1:0] count_q;
  logic                    push_en;
  logic                    pop_en;

  // Circular pointer advance
  function automatic logic [`FETCH_CNT_W-1:0] next_ptr(input logic [`FETCH_CNT_W-1:0] ptr);
    logic [`FETCH_CNT_W-1:0] nxt;
    nxt = (ptr == `FETCH_CNT_W'(`FETCH_DEPTH-1)) ? '0 : ptr + 1'b1;
    return nxt;
  endfunction

  ////////////////////
  // Enables
  ////////////////////

  assign pop_en  = pop_i && valid_o && !flush_i;
  // Full buffer only accepts when a pop frees a slot
  assign push_en = push_i && !flush_i &&
                   ((count_q != `FETCH_CNT_W'(`FETCH_DEPTH)) || pop_en);

  ////////////////////
  // Pointers and count
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop_en) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({push_en, pop_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push_en) begin
      mem_q[wr_ptr_q] <= push_entry_i;
    end
  end

  assign valid_o = (count_q != '0);
  assign entry_o = mem_q[rd_ptr_q];
  assign count_o = count_q;

endmodule

// File: instr_obi_master.sv
// Instruction bus OBI master

`timescale 1ns/100ps

`include "fetch_config.svh"

module instr_obi_master (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     trans_valid_i,
  input  fetch_pkg::fetch_req_t    trans_i,
  output logic                     trans_ready_o,
  input  logic                     instr_gnt_i,
  output logic                     instr_req_o,
  output logic [`FETCH_ADDR_W-1:0] instr_addr_o
);

  import fetch_pkg::*;

  logic       req_q;
  fetch_req_t trans_q;
  logic       accept;

  ////////////////////
  // Handshake
  ////////////////////

  // Free when idle or when the pending request is granted now
  assign trans_ready_o = !req_q || instr_gnt_i;
  assign accept        = trans_valid_i && trans_ready_o;

  // Request stays up until grant
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q <= 1'b0;
    end else if (accept) begin
      req_q <= 1'b1;
    end else if (instr_gnt_i) begin
      req_q <= 1'b0;
    end
  end

  // Holding register keeps the address stable while waiting
  always_ff @(posedge clk) begin
    if (accept) begin
      trans_q <= trans_i;
    end
  end

  assign instr_req_o  = req_q;
  assign instr_addr_o = trans_q.addr;

endmodule

// File: if_stage.sv
// Instruction fetch stage top

`timescale 1ns/100ps

`include "fetch_config.svh"

module if_stage (
  input  logic                      clk,
  input  logic                      rst_n,
  input  fetch_pkg::fetch_ctrl_t    ctrl_i,
  input  fetch_pkg::fetch_targets_t targets_i,
  input  logic                      id_ready_i,
  output logic                      instr_req_o,
  output logic [`FETCH_ADDR_W-1:0]  instr_addr_o,
  input  logic                      instr_gnt_i,
  input  logic                      instr_rvalid_i,
  input  logic [`FETCH_ADDR_W-1:0]  instr_rdata_i,
  input  logic                      instr_err_i,
  output fetch_pkg::if_id_pipe_t    if_id_pipe_o,
  output logic [`FETCH_ADDR_W-1:0]  pc_if_o,
  output logic                      if_valid_o,
  output logic                      mtvec_init_o,
  output logic                      busy_o,
  output logic                      protocol_err_o
);

  import fetch_pkg::*;

  logic [`FETCH_ADDR_W-1:0] branch_addr;
  logic                     trans_valid;
  logic                     trans_ready;
  fetch_req_t               trans;
  instr_resp_t              bus_resp;
  logic                     push;
  fetch_entry_t             push_entry;
  logic                     fifo_valid;
  fetch_entry_t             fifo_entry;
  logic [`FETCH_CNT_W-1:0]  fifo_count;
  logic                     fifo_pop;
  logic                     instr_valid_q;
  logic [`FETCH_ADDR_W-1:0] instr_q;
  logic [`FETCH_ADDR_W-1:0] pc_q;
  logic                     bus_err_q;

  pc_select pc_select_i (
    .ctrl_i        (ctrl_i),
    .targets_i     (targets_i),
    .branch_addr_o (branch_addr)
  );

  assign bus_resp.rdata = instr_rdata_i;
  assign bus_resp.err   = instr_err_i;

  prefetch_ctrl prefetch_ctrl_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .pc_set_i       (ctrl_i.pc_set),
    .branch_addr_i  (branch_addr),
    .trans_ready_i  (trans_ready),
    .resp_valid_i   (instr_rvalid_i),
    .resp_i         (bus_resp),
    .fifo_count_i   (fifo_count),
    .trans_valid_o  (trans_valid),
    .trans_o        (trans),
    .push_o         (push),
    .push_entry_o   (push_entry),
    .busy_o         (busy_o),
    .protocol_err_o (protocol_err_o)
  );

  // Redirect empties the buffer
  fetch_fifo fetch_fifo_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (ctrl_i.pc_set),
    .push_i       (push),
    .push_entry_i (push_entry),
    .pop_i        (fifo_pop),
    .valid_o      (fifo_valid),
    .entry_o      (fifo_entry),
    .count_o      (fifo_count)
  );

  instr_obi_master instr_obi_master_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .trans_valid_i (trans_valid),
    .trans_i       (trans),
    .trans_ready_o (trans_ready),
    .instr_gnt_i   (instr_gnt_i),
    .instr_req_o   (instr_req_o),
    .instr_addr_o  (instr_addr_o)
  );

  ////////////////////
  // Valid and ready
  ////////////////////

  assign if_valid_o = fifo_valid && !ctrl_i.kill_if && !ctrl_i.halt_if;
  // Kill drains the head regardless of ID
  assign fifo_pop   = fifo_valid && (ctrl_i.kill_if || (id_ready_i && !ctrl_i.halt_if));
  assign pc_if_o    = fifo_entry.addr;

  // Tell the CSR file to initialise mtvec on boot
  assign mtvec_init_o = ctrl_i.pc_set && (ctrl_i.pc_mux == PC_BOOT);

  ////////////////////
  // IF/ID register
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_valid_q <= 1'b0;
    end else if (id_ready_i) begin
      instr_valid_q <= if_valid_o;
    end
  end

  // Payload frozen while ID stalls
  always_ff @(posedge clk) begin
    if (if_valid_o && id_ready_i) begin
      instr_q   <= fifo_entry.resp.rdata;
      pc_q      <= fifo_entry.addr;
      bus_err_q <= fifo_entry.resp.err;
    end
  end

  assign if_id_pipe_o.instr_valid = instr_valid_q;
  assign if_id_pipe_o.instr       = instr_q;
  assign if_id_pipe_o.pc          = pc_q;
  assign if_id_pipe_o.bus_err     = bus_err_q;

endmodule

// File: tb_fetch_stage.sv
// Fetch stage testbench

`timescale 1ns/100ps

`include "fetch_config.svh"

module tb_fetch_stage;

  import fetch_pkg::*;

  // Read data rule and bus error window of two words
  localparam logic [31:0] data_key = 32'h5A5A_0000;
  localparam logic [31:0] err_lo   = 32'h0000_7010;
  localparam logic [31:0] err_hi   = 32'h0000_7018;

  logic           clk;
  logic           rst_n;
  fetch_ctrl_t    ctrl;
  fetch_targets_t targets;
  logic           id_ready;
  logic           instr_gnt    = 1'b0;
  logic           instr_rvalid = 1'b0;
  logic [31:0]    instr_rdata  = '0;
  logic           instr_err    = 1'b0;
  logic           instr_req;
  logic [31:0]    instr_addr;
  if_id_pipe_t    pipe;
  logic [31:0]    pc_if;
  logic           if_valid;
  logic           mtvec_init;
  logic           busy;
  logic           protocol_err;

  // Scoreboard state
  int          errors      = 0;
  int          delivered   = 0;
  int          err_words   = 0;
  int          init_pulses = 0;
  int          prot_pulses = 0;
  int          inject_req  = 0;
  int          inject_done = 0;
  int          cyc         = 0;
  int          seed;
  logic [31:0] exp_pc      = '0;
  logic [31:0] exp_target  = '0;
  logic        load_seen   = 1'b0;
  logic        ready_prev  = 1'b0;

  // Bus model state
  logic [31:0] addr_q [$];
  int          due_q [$];
  int          gnt_wait  = 0;
  logic        gnt_armed = 1'b0;
  logic        req_prev  = 1'b0;
  logic        gnt_prev  = 1'b0;
  logic [31:0] addr_prev = '0;

  if_stage if_stage_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .ctrl_i         (ctrl),
    .targets_i      (targets),
    .id_ready_i     (id_ready),
    .instr_req_o    (instr_req),
    .instr_addr_o   (instr_addr),
    .instr_gnt_i    (instr_gnt),
    .instr_rvalid_i (instr_rvalid),
    .instr_rdata_i  (instr_rdata),
    .instr_err_i    (instr_err),
    .if_id_pipe_o   (pipe),
    .pc_if_o        (pc_if),
    .if_valid_o     (if_valid),
    .mtvec_init_o   (mtvec_init),
    .busy_o         (busy),
    .protocol_err_o (protocol_err)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // About 500 cycles per test at 8 ns plus margin
  initial begin
    #40000;
    $display("Timeout: run did not finish within 40 us");
    $display("Verification failed");
    $finish;
  end

  function automatic logic in_err_window(input logic [31:0] addr);
    return (addr >= err_lo) && (addr < err_hi);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    $display("%0t test %s finished with %0d errors", $time, name, errors - err_start);
  endtask

  task automatic wait_words(input int n);
    int target;
    int waited;
    target = delivered + n;
    waited = 0;
    while (delivered < target && waited < 200) begin
      @(negedge clk);
      waited++;
    end
    if (delivered < target) begin
      $display("%0t only %0d of %0d words delivered in time", $time, n - (target - delivered), n);
      errors++;
    end
  endtask

  // One-cycle redirect strobe with kill
  task automatic redirect(input pc_mux_e mux, input logic [4:0] irq, input logic [31:0] target);
    @(negedge clk);
    exp_target     = target;
    ctrl.pc_set    = 1'b1;
    ctrl.kill_if   = 1'b1;
    ctrl.pc_mux    = mux;
    ctrl.irq_index = irq;
    @(negedge clk);
    ctrl.pc_set    = 1'b0;
    ctrl.kill_if   = 1'b0;
  endtask

  ////////////////////
  // Bus memory model
  ////////////////////

  always @(negedge clk) begin
    cyc++;
    instr_gnt    = 1'b0;
    instr_rvalid = 1'b0;
    if (!rst_n) begin
      addr_q.delete();
      due_q.delete();
      gnt_armed = 1'b0;
      req_prev  = 1'b0;
    end else begin
      // Outstanding from handover until response
      check_value("busy_o", 32'(busy), 32'((addr_q.size() != 0) || instr_req));
      // OBI request and address hold until grant
      if (req_prev && !gnt_prev && !instr_req) begin
        $display("%0t request withdrawn before grant", $time);
        errors++;
      end
      if (req_prev && !gnt_prev && instr_req) begin
        check_value("instr_addr_o", instr_addr, addr_prev);
      end
      // In-order responses
      if (due_q.size() > 0 && due_q[0] <= cyc) begin
        instr_rvalid = 1'b1;
        instr_rdata  = addr_q[0] ^ data_key;
        instr_err    = in_err_window(addr_q[0]);
        void'(addr_q.pop_front());
        void'(due_q.pop_front());
      end else if (inject_done != inject_req && due_q.size() == 0) begin
        // Stray response with nothing outstanding
        instr_rvalid = 1'b1;
        instr_rdata  = 32'hDEAD_BEEF;
        instr_err    = 1'b0;
        inject_done++;
      end
      if (instr_req) begin
        if (!gnt_armed) begin
          gnt_wait  = $urandom_range(2, 0);
          gnt_armed = 1'b1;
        end
        if (gnt_wait == 0) begin
          instr_gnt = 1'b1;
          gnt_armed = 1'b0;
          addr_q.push_back(instr_addr);
          due_q.push_back(cyc + $urandom_range(3, 1));
          if (addr_q.size() > 2) begin
            $display("%0t %0d transactions granted and unanswered", $time, addr_q.size());
            errors++;
          end
        end else begin
          gnt_wait--;
        end
      end
      req_prev  = instr_req;
      gnt_prev  = instr_gnt;
      addr_prev = instr_addr;
    end
  end

  ////////////////////
  // Delivery monitor
  ////////////////////

  // Sampled at the edge before the DUT registers update
  always @(posedge clk) begin
    if (!rst_n) begin
      load_seen  = 1'b0;
      ready_prev = 1'b0;
    end else begin
      if (load_seen) begin
        check_value("if_id_pipe_o.instr_valid", 32'(pipe.instr_valid), 32'd1);
        check_value("if_id_pipe_o.pc", pipe.pc, exp_pc);
        check_value("if_id_pipe_o.instr", pipe.instr, exp_pc ^ data_key);
        check_value("if_id_pipe_o.bus_err", 32'(pipe.bus_err), 32'(in_err_window(exp_pc)));
        exp_pc = exp_pc + 32'd4;
        delivered++;
        if (pipe.bus_err) begin
          err_words++;
        end
      end else if (ready_prev) begin
        // ID took nothing last cycle
        check_value("if_id_pipe_o.instr_valid", 32'(pipe.instr_valid), 32'd0);
      end
      if (mtvec_init) begin
        init_pulses++;
      end
      if (protocol_err) begin
        prot_pulses++;
      end
      if (ctrl.pc_set) begin
        exp_pc = exp_target;
      end
      // Head word is offered only without kill or halt
      if (ctrl.kill_if || ctrl.halt_if) begin
        check_value("if_valid_o", 32'(if_valid), 32'd0);
      end
      if (if_valid && id_ready) begin
        check_value("pc_if_o", pc_if, exp_pc);
      end
      load_seen  = if_valid && id_ready;
      ready_prev = id_ready;
    end
  end

  ////////////////////
  // Tests
  ////////////////////

  task automatic boot_stream_test();
    int err_start;
    err_start = errors;
    check_value("instr_req_o", 32'(instr_req), 32'd0);
    check_value("if_id_pipe_o.instr_valid", 32'(pipe.instr_valid), 32'd0);
    check_value("mtvec_init_o", 32'(mtvec_init), 32'd0);
    check_value("busy_o", 32'(busy), 32'd0);
    check_value("protocol_err_o", 32'(protocol_err), 32'd0);
    redirect(PC_BOOT, 5'd0, targets.boot_addr & 32'hFFFF_FFFC);
    wait_words(8);
    check_value("mtvec_init_o pulse count", init_pulses, 32'd1);
    report_test("boot_stream", err_start);
  endtask

  task automatic redirect_test();
    int err_start;
    err_start = errors;
    redirect(PC_JUMP, 5'd0, targets.jump_target);
    wait_words(3);
    repeat ($urandom_range(3, 0)) @(negedge clk);
    redirect(PC_BRANCH, 5'd0, targets.branch_target);
    wait_words(5);
    report_test("redirect", err_start);
  endtask

  task automatic trap_target_test();
    int          err_start;
    logic [31:0] base;
    err_start = errors;
    base = {targets.mtvec_base, 7'd0};
    redirect(PC_TRAP_EXC, 5'd0, base);
    wait_words(4);
    redirect(PC_TRAP_IRQ, 5'd5, base + 32'd5 * 32'd4);
    wait_words(4);
    redirect(PC_DBG_HALT, 5'd0, targets.dm_halt_addr & 32'hFFFF_FFFC);
    wait_words(4);
    redirect(PC_MRET, 5'd0, targets.mepc);
    wait_words(4);
    // Only the boot redirect initialises mtvec
    check_value("mtvec_init_o pulse count", init_pulses, 32'd1);
    report_test("trap_target", err_start);
  endtask

  task automatic backpressure_test();
    int   err_start;
    int   start_words;
    int   len;
    logic stall;
    logic hold;
    err_start   = errors;
    start_words = delivered;
    repeat (30) begin
      len   = $urandom_range(8, 1);
      stall = 1'($urandom_range(1, 0));
      hold  = ($urandom_range(3, 0) == 0);
      repeat (len) begin
        @(negedge clk);
        id_ready      = !stall;
        ctrl.halt_if  = hold;
      end
    end
    @(negedge clk);
    id_ready     = 1'b1;
    ctrl.halt_if = 1'b0;
    wait_words(4);
    if (delivered - start_words < 10) begin
      $display("%0t stall phase delivered only %0d words", $time, delivered - start_words);
      errors++;
    end
    report_test("backpressure", err_start);
  endtask

  task automatic bus_error_test();
    int err_start;
    int err_before;
    err_start = errors;
    @(negedge clk);
    targets.jump_target = 32'h0000_7008;
    err_before = err_words;
    redirect(PC_JUMP, 5'd0, 32'h0000_7008);
    wait_words(6);
    check_value("bus_err word count", err_words - err_before, 32'd2);
    report_test("bus_error", err_start);
  endtask

  task automatic protocol_error_test();
    int err_start;
    int waited;
    err_start = errors;
    check_value("protocol_err_o pulse count", prot_pulses, 32'd0);
    @(negedge clk);
    id_ready = 1'b0;
    // Full buffer stops prefetching
    waited = 0;
    while ((busy || instr_req) && waited < 100) begin
      @(negedge clk);
      waited++;
    end
    if (busy || instr_req) begin
      $display("%0t bus did not go idle with ID stalled", $time);
      errors++;
    end
    @(posedge clk);
    inject_req++;
    waited = 0;
    while (prot_pulses == 0 && waited < 10) begin
      @(negedge clk);
      waited++;
    end
    repeat (3) @(negedge clk);
    check_value("protocol_err_o pulse count", prot_pulses, 32'd1);
    check_value("busy_o", 32'(busy), 32'd0);
    id_ready = 1'b1;
    wait_words(4);
    report_test("protocol_error", err_start);
  endtask

  initial begin
    rst_n                 = 1'b0;
    ctrl                  = '0;
    id_ready              = 1'b1;
    targets.boot_addr     = 32'h0000_1002;
    targets.jump_target   = 32'h0000_4000;
    targets.branch_target = 32'h0000_5000;
    targets.mepc          = 32'h0000_6100;
    targets.dm_halt_addr  = 32'h0000_8003;
    targets.mtvec_base    = 25'h60;
    seed = $urandom(43);
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    boot_stream_test();
    redirect_test();
    trap_target_test();
    backpressure_test();
    bus_error_test();
    protocol_error_test();
    $display("Tests run: 6, errors: %0d, words delivered: %0d", errors, delivered);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: fetch_stage.f
+incdir+.
fetch_pkg.sv
pc_select.sv
prefetch_ctrl.sv
fetch_fifo.sv
instr_obi_master.sv
if_stage.sv
tb_fetch_stage.sv

// File: Makefile
# Verilator build and run for the fetch stage

TOP = tb_fetch_stage

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f fetch_stage.f --top-module $(TOP) -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "^Verification passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
